// File: spi_boot.f
+incdir+.
boot_pkg.sv
spi_frame_rx.sv
boot_ctrl.sv
sram_main.sv
status_watch.sv
spi_boot_top.sv
tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := tb
RTL_TOP   := spi_boot_top
FILELIST  := spi_boot.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# pass only if the run prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_tasks.svh
/*
 * Typed compare tasks, host read handshake, frame writes and the
 * directed tests of the SPI boot testbench.
 */

task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input string what);
  if (got !== exp) begin
    $display("error %0t: %s got %h, expected %h", $time, what, got, exp);
    errors++;
  end
endtask

task automatic check_event(input ev_kind_e kind, input logic [DATA_W-1:0] exp);
  logic [DATA_W-1:0] got;
  int                seen;
  int                other;
  string             name;
  got = '0;
  if (kind == EV_STATUS) begin
    name  = "status";
    seen  = status_evq.size();
    other = log_evq.size();
    if (seen > 0) begin
      got = status_evq.pop_front();
    end
  end else begin
    name  = "log";
    seen  = log_evq.size();
    other = status_evq.size();
    if (seen > 0) begin
      got = log_evq.pop_front();
    end
  end
  if (seen == 0) begin
    $display("no %s event was reported for the %s word write", name, name);
    errors++;
  end else begin
    check_word(got, exp, {name, " event data"});
  end
  if (seen > 1) begin
    $display("%s event reported %0d times for one write", name, seen);
    errors++;
  end
  if (other > 0) begin
    $display("%s word write also raised the other event", name);
    errors++;
  end
  status_evq.delete();
  log_evq.delete();
endtask

// four-phase host read
task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
  int wait_cnt;
  if (rd_ack !== 1'b0) begin
    $display("read ack was high before the request was raised");
    errors++;
  end
  rd_addr  = addr;
  rd_req   = 1'b1;
  wait_cnt = 0;
  while (rd_ack !== 1'b1 && wait_cnt < HS_TIMEOUT) begin
    next_cycle(1);
    wait_cnt++;
  end
  if (rd_ack !== 1'b1) begin
    $display("read of address %h was never acknowledged", addr);
    errors++;
  end
  data     = rd_data;
  rd_req   = 1'b0;
  wait_cnt = 0;
  while (rd_ack !== 1'b0 && wait_cnt < HS_TIMEOUT) begin
    next_cycle(1);
    wait_cnt++;
  end
  if (rd_ack !== 1'b0) begin
    $display("read ack did not fall after the request was dropped");
    errors++;
  end
endtask

task automatic verify_read(input logic [ADDR_W-1:0] addr, input string what);
  logic [DATA_W-1:0] data;
  host_read(addr, data);
  check_word(data, ref_mem[addr], what);
endtask

task automatic frame_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
  spi_send(make_frame(addr, data), FRAME_W);
  ref_mem[addr] = data;
endtask

// top bit splits the base and stream address ranges
task automatic pick_addr(input logic top, output logic [ADDR_W-1:0] addr);
  logic [31:0] v;
  take_bits(ADDR_W - 1, v);
  addr = {top, v[ADDR_W-2:0]};
  if (addr == TEST_STATUS_ADDR || addr == LOG_ADDR) begin
    addr[0] = ~addr[0];
  end
endtask

task automatic reset_state_low();
  if (rd_ack !== 1'b0 || status_valid !== 1'b0 || log_valid !== 1'b0) begin
    $display("outputs not low after reset: rd_ack %b status_valid %b log_valid %b",
             rd_ack, status_valid, log_valid);
    errors++;
  end
endtask

task automatic fill_and_read();
  logic [ADDR_W-1:0] addr;
  logic [31:0]       v;
  for (int i = 0; i < N_BASE; i++) begin
    pick_addr(1'b0, addr);
    take_bits(DATA_W, v);
    frame_write(addr, v);
    base_addrs.push_back(addr);
  end
  foreach (base_addrs[i]) begin
    verify_read(base_addrs[i], "read after fill");
  end
endtask

task automatic strap_low_drop();
  logic [31:0] v;
  bootstrap = 1'b0;
  next_cycle(4);
  for (int i = 0; i < N_DROP; i++) begin
    take_bits(DATA_W, v);
    spi_send(make_frame(base_addrs[i], v), FRAME_W);
  end
  for (int i = 0; i < N_DROP; i++) begin
    verify_read(base_addrs[i], "read after dropped frame");
  end
  bootstrap = 1'b1;
  next_cycle(4);
endtask

task automatic status_log_events();
  logic [31:0] v;
  take_bits(DATA_W, v);
  frame_write(TEST_STATUS_ADDR, v);
  verify_read(TEST_STATUS_ADDR, "status word read");
  check_event(EV_STATUS, v);
  take_bits(DATA_W, v);
  frame_write(LOG_ADDR, v);
  verify_read(LOG_ADDR, "log word read");
  check_event(EV_LOG, v);
endtask

task automatic aborted_frame();
  logic [ADDR_W-1:0] addr;
  logic [31:0]       v;
  addr = base_addrs[0];
  take_bits(DATA_W, v);
  // address field and part of the data, then csb high
  spi_send(make_frame(addr, v), 30);
  verify_read(addr, "word after aborted frame");
  take_bits(DATA_W, v);
  frame_write(addr, v);
  verify_read(addr, "frame after abort");
endtask

task automatic reads_during_stream();
  logic [ADDR_W-1:0] addr;
  logic [31:0]       v;
  logic              stream_done;
  int                j;
  stream_done = 1'b0;
  j           = 0;
  fork
    begin
      for (int i = 0; i < N_STREAM; i++) begin
        pick_addr(1'b1, addr);
        take_bits(DATA_W, v);
        frame_write(addr, v);
        stream_addrs.push_back(addr);
      end
      stream_done = 1'b1;
    end
    begin
      while (!stream_done) begin
        verify_read(base_addrs[j % base_addrs.size()], "read during stream");
        next_cycle(3 + j % 5);
        j++;
      end
    end
  join
  foreach (stream_addrs[i]) begin
    verify_read(stream_addrs[i], "read of streamed frame");
  end
endtask

// File: tb.sv
/*
 * Testbench top for the SPI boot subsystem: clock, reset, watchdog,
 * LFSR stimulus source, SPI pin driver and the test sequence.
 */
`timescale 1ns/1ps

module tb;
  import boot_pkg::*;

  localparam int     SCK_HALF    = 4;
  localparam int     N_BASE      = 16;
  localparam int     N_DROP      = 4;
  localparam int     N_STREAM    = 8;
  localparam int     N_FRAMES    = N_BASE + N_DROP + N_STREAM + 4;
  localparam longint WATCHDOG_NS = longint'(N_FRAMES) * FRAME_W * 64 + 40_000;
  localparam int     HS_TIMEOUT  = 200;

  typedef enum {EV_STATUS, EV_LOG} ev_kind_e;

  logic              clk;
  logic              arst_n;
  logic              bootstrap;
  logic              spi_sck;
  logic              spi_csb;
  logic              spi_sdi;
  logic              rd_req;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_ack;
  logic [DATA_W-1:0] rd_data;
  logic              status_valid;
  logic [DATA_W-1:0] status_data;
  logic              log_valid;
  logic [DATA_W-1:0] log_data;

  // expected RAM contents and the addresses used so far
  logic [DATA_W-1:0] ref_mem [DEPTH];
  logic [ADDR_W-1:0] base_addrs [$];
  logic [ADDR_W-1:0] stream_addrs [$];
  logic [DATA_W-1:0] status_evq [$];
  logic [DATA_W-1:0] log_evq [$];
  logic [31:0]       lfsr_q;
  int                errors;

  spi_boot_top dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .bootstrap_i    (bootstrap),
    .spi_sck_i      (spi_sck),
    .spi_csb_i      (spi_csb),
    .spi_sdi_i      (spi_sdi),
    .rd_req_i       (rd_req),
    .rd_addr_i      (rd_addr),
    .rd_ack_o       (rd_ack),
    .rd_data_o      (rd_data),
    .status_valid_o (status_valid),
    .status_o       (status_data),
    .log_valid_o    (log_valid),
    .log_data_o     (log_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // event monitor, sampled away from the active edge
  always @(negedge clk) begin
    if (status_valid) begin
      status_evq.push_back(status_data);
    end
    if (log_valid) begin
      log_evq.push_back(log_data);
    end
  end

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic next_cycle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // unused upper address bits sent as zero
  function automatic logic [FRAME_W-1:0] make_frame(input logic [ADDR_W-1:0] addr,
                                                    input logic [DATA_W-1:0] data);
    return {{(FRAME_W - ADDR_W - DATA_W){1'b0}}, addr, data};
  endfunction

  // msb first, sdi changes with the falling sck edge
  task automatic spi_send(input logic [FRAME_W-1:0] bits, input int nbits);
    spi_csb = 1'b0;
    next_cycle(SCK_HALF);
    for (int i = 0; i < nbits; i++) begin
      spi_sdi = bits[FRAME_W-1-i];
      spi_sck = 1'b0;
      next_cycle(SCK_HALF);
      spi_sck = 1'b1;
      next_cycle(SCK_HALF);
    end
    spi_sck = 1'b0;
    next_cycle(SCK_HALF);
    spi_csb = 1'b1;
    next_cycle(SCK_HALF);
  endtask

  `include "tb_tasks.svh"

  initial begin
    arst_n    = 1'b0;
    bootstrap = 1'b1;
    spi_sck   = 1'b0;
    spi_csb   = 1'b1;
    spi_sdi   = 1'b0;
    rd_req    = 1'b0;
    rd_addr   = '0;
    lfsr_q    = 32'hb655_4866;
    errors    = 0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    reset_state_low();
    fill_and_read();
    strap_low_drop();
    status_log_events();
    aborted_frame();
    reads_during_stream();
    if (status_evq.size() != 0 || log_evq.size() != 0) begin
      $display("status or log event reported for a write that should not raise one");
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: spi_boot_top.sv
/*
 * SPI boot subsystem top: receiver, RAM arbiter, main RAM and status monitor.
 */
`timescale 1ns/1ps

module spi_boot_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        bootstrap_i,
  input  logic                        spi_sck_i,
  input  logic                        spi_csb_i,
  input  logic                        spi_sdi_i,
  input  logic                        rd_req_i,
  input  logic [boot_pkg::ADDR_W-1:0] rd_addr_i,
  output logic                        rd_ack_o,
  output logic [boot_pkg::DATA_W-1:0] rd_data_o,
  output logic                        status_valid_o,
  output logic [boot_pkg::DATA_W-1:0] status_o,
  output logic                        log_valid_o,
  output logic [boot_pkg::DATA_W-1:0] log_data_o
);
  import boot_pkg::*;

  logic              frm_req;
  logic              frm_ack;
  spi_frame_t        frame;
  logic              mem_req;
  logic              mem_ack;
  mem_req_t          mem;
  logic [DATA_W-1:0] rdata;
  logic              wr_fire;

  spi_frame_rx u_spi_frame_rx (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .spi_sck_i (spi_sck_i),
    .spi_csb_i (spi_csb_i),
    .spi_sdi_i (spi_sdi_i),
    .frm_ack_i (frm_ack),
    .frm_req_o (frm_req),
    .frame_o   (frame)
  );

  boot_ctrl u_boot_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .bootstrap_i (bootstrap_i),
    .frm_req_i   (frm_req),
    .frame_i     (frame),
    .rd_req_i    (rd_req_i),
    .rd_addr_i   (rd_addr_i),
    .mem_ack_i   (mem_ack),
    .rdata_i     (rdata),
    .frm_ack_o   (frm_ack),
    .rd_ack_o    (rd_ack_o),
    .rd_data_o   (rd_data_o),
    .mem_req_o   (mem_req),
    .mem_o       (mem),
    .wr_fire_o   (wr_fire)
  );

  sram_main u_sram_main (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .mem_req_i (mem_req),
    .mem_i     (mem),
    .mem_ack_o (mem_ack),
    .rdata_o   (rdata)
  );

  status_watch u_status_watch (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .wr_fire_i      (wr_fire),
    .wr_i           (mem),
    .status_valid_o (status_valid_o),
    .status_o       (status_o),
    .log_valid_o    (log_valid_o),
    .log_data_o     (log_data_o)
  );

endmodule

// File: status_watch.sv
/*
 * Monitor of accepted RAM writes: flags test-status and log word writes
 * and registers the written data.
 */
`timescale 1ns/1ps

module status_watch (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        wr_fire_i,
  input  boot_pkg::mem_req_t          wr_i,
  output logic                        status_valid_o,
  output logic [boot_pkg::DATA_W-1:0] status_o,
  output logic                        log_valid_o,
  output logic [boot_pkg::DATA_W-1:0] log_data_o
);
  import boot_pkg::*;

  logic              status_hit;
  logic              log_hit;
  logic              status_valid_q;
  logic              log_valid_q;
  logic [DATA_W-1:0] status_q;
  logic [DATA_W-1:0] log_q;

  assign status_hit = wr_fire_i && wr_i.write && (wr_i.addr == TEST_STATUS_ADDR);
  assign log_hit    = wr_fire_i && wr_i.write && (wr_i.addr == LOG_ADDR);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_valid_q <= 1'b0;
      log_valid_q    <= 1'b0;
    end else begin
      status_valid_q <= status_hit;
      log_valid_q    <= log_hit;
    end
  end

  // data holds until the next matching write
  always_ff @(posedge clk_i) begin
    if (status_hit) begin
      status_q <= wr_i.wdata;
    end
    if (log_hit) begin
      log_q <= wr_i.wdata;
    end
  end

  assign status_valid_o = status_valid_q;
  assign status_o       = status_q;
  assign log_valid_o    = log_valid_q;
  assign log_data_o     = log_q;

endmodule

// File: sram_main.sv
/*
 * Single-port main RAM of DEPTH words with a registered four-phase ack.
 */
`timescale 1ns/1ps

module sram_main (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        mem_req_i,
  input  boot_pkg::mem_req_t          mem_i,
  output logic                        mem_ack_o,
  output logic [boot_pkg::DATA_W-1:0] rdata_o
);
  import boot_pkg::*;

  logic [DATA_W-1:0] mem_q [DEPTH];
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;
  logic              access;

  // one access per handshake, on the edge that raises ack
  assign access = mem_req_i && !ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= mem_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (mem_i.write) begin
        mem_q[mem_i.addr] <= mem_i.wdata;
      end else begin
        rdata_q <= mem_q[mem_i.addr];
      end
    end
  end

  assign mem_ack_o = ack_q;
  assign rdata_o   = rdata_q;

endmodule

// File: boot_ctrl.sv
/*
 * RAM arbiter FSM: SPI write frames over host reads, bootstrap strap gate,
 * four-phase handshakes on all three sides and the accepted-write pulse.
 */
`timescale 1ns/1ps

module boot_ctrl (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        bootstrap_i,
  input  logic                        frm_req_i,
  input  boot_pkg::spi_frame_t        frame_i,
  input  logic                        rd_req_i,
  input  logic [boot_pkg::ADDR_W-1:0] rd_addr_i,
  input  logic                        mem_ack_i,
  input  logic [boot_pkg::DATA_W-1:0] rdata_i,
  output logic                        frm_ack_o,
  output logic                        rd_ack_o,
  output logic [boot_pkg::DATA_W-1:0] rd_data_o,
  output logic                        mem_req_o,
  output boot_pkg::mem_req_t          mem_o,
  output logic                        wr_fire_o
);
  import boot_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_RELEASE
  } state_e;

  state_e            state_q;
  logic [1:0]        boot_q;
  logic              serve_frm_q;
  logic              mem_req_q;
  logic              frm_ack_q;
  logic              rd_ack_q;
  mem_req_t          mem_q;
  logic [DATA_W-1:0] rd_data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= ST_IDLE;
      boot_q      <= '0;
      serve_frm_q <= 1'b0;
      mem_req_q   <= 1'b0;
      frm_ack_q   <= 1'b0;
      rd_ack_q    <= 1'b0;
    end else begin
      // strap comes straight from a pad
      boot_q <= {boot_q[0], bootstrap_i};
      case (state_q)
        ST_IDLE: begin
          if (frm_req_i) begin
            serve_frm_q <= 1'b1;
            if (boot_q[1]) begin
              mem_req_q <= 1'b1;
              state_q   <= ST_WRITE;
            end else begin
              // strap low, frame is acked and thrown away
              frm_ack_q <= 1'b1;
              state_q   <= ST_RELEASE;
            end
          end else if (rd_req_i) begin
            serve_frm_q <= 1'b0;
            mem_req_q   <= 1'b1;
            state_q     <= ST_READ;
          end
        end
        ST_WRITE: begin
          if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            frm_ack_q <= 1'b1;
            state_q   <= ST_RELEASE;
          end
        end
        ST_READ: begin
          if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            rd_ack_q  <= 1'b1;
            state_q   <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          // wait for both sides to return to zero
          if (!mem_ack_i && serve_frm_q && !frm_req_i) begin
            frm_ack_q <= 1'b0;
            state_q   <= ST_IDLE;
          end else if (!mem_ack_i && !serve_frm_q && !rd_req_i) begin
            rd_ack_q <= 1'b0;
            state_q  <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE) begin
      if (frm_req_i) begin
        mem_q <= '{write: 1'b1, addr: frame_i.addr, wdata: frame_i.data};
      end else begin
        mem_q <= '{write: 1'b0, addr: rd_addr_i, wdata: '0};
      end
    end
    if (state_q == ST_READ && mem_ack_i) begin
      rd_data_q <= rdata_i;
    end
  end

  assign frm_ack_o = frm_ack_q;
  assign rd_ack_o  = rd_ack_q;
  assign rd_data_o = rd_data_q;
  assign mem_req_o = mem_req_q;
  assign mem_o     = mem_q;
  // single cycle, the FSM leaves ST_WRITE on the same ack
  assign wr_fire_o = (state_q == ST_WRITE) && mem_ack_i;

endmodule

// File: spi_frame_rx.sv
/*
 * SPI device receiver: pin synchronizers, SCK edge detect, 48-bit shift register
 * and a holding register offered to the controller by four-phase req/ack.
 */
`timescale 1ns/1ps

module spi_frame_rx (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 spi_sck_i,
  input  logic                 spi_csb_i,
  input  logic                 spi_sdi_i,
  input  logic                 frm_ack_i,
  output logic                 frm_req_o,
  output boot_pkg::spi_frame_t frame_o
);
  import boot_pkg::*;

  logic [2:0]           sck_q;
  logic [1:0]           csb_q;
  logic [1:0]           sdi_q;
  logic                 sck_rise_q;
  logic [BIT_CNT_W-1:0] bit_cnt_q;
  logic [FRAME_W-1:0]   shift_q;
  logic                 full_q;
  logic                 req_q;
  spi_frame_t           hold_q;
  logic                 shift_en;
  logic                 load;

  // shift register is frozen once full, until the holding register takes it
  assign shift_en = sck_rise_q && !csb_q[1] && !full_q;
  // holding register is free once the previous handshake has fully returned to zero
  assign load = full_q && !req_q && !frm_ack_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_q      <= '0;
      csb_q      <= '1;
      sdi_q      <= '0;
      sck_rise_q <= 1'b0;
      bit_cnt_q  <= '0;
      full_q     <= 1'b0;
      req_q      <= 1'b0;
    end else begin
      sck_q      <= {sck_q[1:0], spi_sck_i};
      csb_q      <= {csb_q[0], spi_csb_i};
      sdi_q      <= {sdi_q[0], spi_sdi_i};
      sck_rise_q <= sck_q[1] && !sck_q[2];

      // csb high drops a partial frame
      if (csb_q[1]) begin
        bit_cnt_q <= '0;
      end else if (shift_en) begin
        if (bit_cnt_q == BIT_CNT_W'(FRAME_W - 1)) begin
          bit_cnt_q <= '0;
          full_q    <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end

      if (load) begin
        full_q <= 1'b0;
        req_q  <= 1'b1;
      end else if (req_q && frm_ack_i) begin
        req_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (shift_en) begin
      shift_q <= {shift_q[FRAME_W-2:0], sdi_q[1]};
    end
    // low ADDR_W bits of the address field, then the data word
    if (load) begin
      hold_q.addr <= shift_q[DATA_W +: ADDR_W];
      hold_q.data <= shift_q[DATA_W-1:0];
    end
  end

  assign frm_req_o = req_q;
  assign frame_o   = hold_q;

endmodule

// File: boot_pkg.sv
/*
 * Shared widths, RAM depth and special word addresses for the SPI boot subsystem,
 * plus the decoded SPI frame struct and the RAM request struct.
 */
package boot_pkg;

  // word address and data widths
  localparam int ADDR_W = 14;
  localparam int DATA_W = 32;
  localparam int DEPTH  = 2 ** ADDR_W;

  // 16-bit address field then 32 data bits, msb first
  localparam int FRAME_W   = 48;
  localparam int BIT_CNT_W = $clog2(FRAME_W);

  // words watched by the test-status and log monitor
  localparam logic [ADDR_W-1:0] TEST_STATUS_ADDR = 14'h3ff0;
  localparam logic [ADDR_W-1:0] LOG_ADDR         = 14'h3ff4;

  // one decoded write frame
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } spi_frame_t;

  // one RAM access
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

endpackage
